// ==== verilog/mmio_pkg.sv ====
package mmio_pkg;

    // word and address width across the subsystem
    parameter int DATA_W = 32;

    // address map, byte addresses from the memory handler
    parameter logic [DATA_W-1:0] MEM_LIMIT      = 32'd2048;    // below this is RAM
    parameter logic [DATA_W-1:0] SPI_CMD_ADDR   = 32'd121212;  // display command byte
    parameter logic [DATA_W-1:0] SPI_PARAM_ADDR = 32'd333333;  // display parameter byte
    parameter logic [DATA_W-1:0] TOUCH_ADDR     = 32'd923923;  // touch result, read only

    // where a request is routed
    typedef enum logic [2:0] {
        TGT_NONE      = 3'd0,
        TGT_MEM       = 3'd1,
        TGT_SPI_CMD   = 3'd2,
        TGT_SPI_PARAM = 3'd3,
        TGT_TOUCH     = 3'd4
    } mmio_target_e;

    // decoder sequencing
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        WAIT_MEM = 2'd1,
        WAIT_SPI = 2'd2,
        FINISH   = 2'd3
    } mmio_state_e;

endpackage

// ==== verilog/mmio_decoder.sv ====
module mmio_decoder (
    input  logic                        clk,
    input  logic                        nRst,
    input  logic                        read_i,
    input  logic                        write_i,
    input  logic [mmio_pkg::DATA_W-1:0] address_i,
    input  logic [mmio_pkg::DATA_W-1:0] data_i,
    input  logic                        mem_done_i,
    input  logic [mmio_pkg::DATA_W-1:0] mem_rdata_i,
    input  logic                        spi_busy_i,
    input  logic [mmio_pkg::DATA_W-1:0] touch_xy_i,
    input  logic                        touch_done_i,
    output logic [mmio_pkg::DATA_W-1:0] data_o,
    output logic                        busy_o,
    output logic                        done_o,
    output logic                        mem_start_o,
    output logic                        mem_we_o,
    output logic [mmio_pkg::DATA_W-1:0] mem_adr_o,
    output logic [mmio_pkg::DATA_W-1:0] mem_wdata_o,
    output logic                        spi_start_o,
    output logic                        spi_is_param_o,
    output logic [7:0]                  spi_byte_o
);

    mmio_pkg::mmio_state_e  state_q, state_d;
    mmio_pkg::mmio_target_e target;
    logic                        valid_req;
    logic                        spi_busy_q;
    logic                        spi_fall;
    logic                        done_d;
    logic [mmio_pkg::DATA_W-1:0] result_q, result_d;

    assign valid_req = read_i ^ write_i;           // both high or both low is no request
    assign spi_fall  = spi_busy_q & ~spi_busy_i;   // transmitter just finished

    always_comb begin
        if (address_i < mmio_pkg::MEM_LIMIT) begin
            target = mmio_pkg::TGT_MEM;
        end else if (address_i == mmio_pkg::SPI_CMD_ADDR) begin
            target = mmio_pkg::TGT_SPI_CMD;
        end else if (address_i == mmio_pkg::SPI_PARAM_ADDR) begin
            target = mmio_pkg::TGT_SPI_PARAM;
        end else if (address_i == mmio_pkg::TOUCH_ADDR) begin
            target = mmio_pkg::TGT_TOUCH;
        end else begin
            target = mmio_pkg::TGT_NONE;
        end
    end

    // memory master and transmitter latch these on their start pulse
    assign mem_we_o       = write_i;
    assign mem_adr_o      = address_i;
    assign mem_wdata_o    = data_i;
    assign spi_byte_o     = data_i[7:0];
    assign spi_is_param_o = (target == mmio_pkg::TGT_SPI_PARAM);

    always_comb begin
        state_d     = state_q;
        result_d    = result_q;
        done_d      = 1'b0;
        mem_start_o = 1'b0;
        spi_start_o = 1'b0;
        case (state_q)
            mmio_pkg::IDLE: begin
                result_d = '0;                     // nothing returned until done
                if (valid_req) begin
                    case (target)
                        mmio_pkg::TGT_MEM: begin
                            mem_start_o = 1'b1;
                            state_d     = mmio_pkg::WAIT_MEM;
                        end
                        mmio_pkg::TGT_SPI_CMD, mmio_pkg::TGT_SPI_PARAM: begin
                            if (read_i) begin
                                state_d = mmio_pkg::FINISH;   // no display readback
                                done_d  = 1'b1;
                            end else if (!spi_busy_i) begin
                                spi_start_o = 1'b1;
                                state_d     = mmio_pkg::WAIT_SPI;
                            end
                        end
                        mmio_pkg::TGT_TOUCH: begin
                            state_d = mmio_pkg::FINISH;
                            done_d  = 1'b1;
                            if (read_i && touch_done_i) begin
                                result_d = touch_xy_i;
                            end
                        end
                        default: begin
                            state_d = mmio_pkg::FINISH;       // unmapped, no effect
                            done_d  = 1'b1;
                        end
                    endcase
                end
            end
            mmio_pkg::WAIT_MEM: begin
                if (mem_done_i) begin
                    state_d = mmio_pkg::FINISH;
                    done_d  = 1'b1;
                    if (read_i) begin
                        result_d = mem_rdata_i;
                    end
                end
            end
            mmio_pkg::WAIT_SPI: begin
                if (spi_fall) begin
                    state_d = mmio_pkg::FINISH;
                    done_d  = 1'b1;
                end
            end
            mmio_pkg::FINISH: begin
                if (!read_i && !write_i) begin     // wait for requester to let go
                    state_d  = mmio_pkg::IDLE;
                    result_d = '0;
                end
            end
            default: state_d = mmio_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state_q    <= mmio_pkg::IDLE;
            result_q   <= '0;
            done_o     <= 1'b0;
            spi_busy_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            result_q   <= result_d;
            done_o     <= done_d;                  // high on entry to FINISH
            spi_busy_q <= spi_busy_i;
        end
    end

    assign data_o = result_q;
    assign busy_o = (state_q == mmio_pkg::WAIT_MEM) || (state_q == mmio_pkg::WAIT_SPI);

    a_done_not_busy: assert property (@(posedge clk) disable iff (!nRst)
        !(done_o && busy_o));

    a_mem_start_idle: assert property (@(posedge clk) disable iff (!nRst)
        mem_start_o |-> (state_q == mmio_pkg::IDLE));

endmodule

// ==== verilog/wb_mem_master.sv ====
module wb_mem_master (
    input  logic                        clk,
    input  logic                        nRst,
    input  logic                        start_i,
    input  logic                        we_i,
    input  logic [mmio_pkg::DATA_W-1:0] adr_i,
    input  logic [mmio_pkg::DATA_W-1:0] wdata_i,
    output logic [mmio_pkg::DATA_W-1:0] rdata_o,
    output logic                        done_o,
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic                        wb_we_o,
    output logic [mmio_pkg::DATA_W-1:0] wb_adr_o,
    output logic [mmio_pkg::DATA_W-1:0] wb_dat_o,
    input  logic [mmio_pkg::DATA_W-1:0] wb_dat_i,
    input  logic                        wb_ack_i
);

    logic active_q;

    // bus control
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            active_q <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (active_q) begin
                if (wb_ack_i) begin
                    active_q <= 1'b0;              // drop cyc/stb after ack
                    done_o   <= 1'b1;
                end
            end else if (start_i) begin
                active_q <= 1'b1;
            end
        end
    end

    // command and result registers
    always_ff @(posedge clk) begin
        if (!active_q && start_i) begin
            wb_we_o  <= we_i;
            wb_adr_o <= adr_i;
            wb_dat_o <= wdata_i;
        end
        if (active_q && wb_ack_i) begin
            rdata_o <= wb_dat_i;                   // read word valid with ack
        end
    end

    assign wb_cyc_o = active_q;
    assign wb_stb_o = active_q;

    a_stb_cyc: assert property (@(posedge clk) disable iff (!nRst)
        wb_stb_o |-> wb_cyc_o);

endmodule

// ==== verilog/wb_ram.sv ====
module wb_ram #(
    parameter int RAM_WORDS = 512
) (
    input  logic                        clk,
    input  logic                        nRst,
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [mmio_pkg::DATA_W-1:0] wb_adr_i,
    input  logic [mmio_pkg::DATA_W-1:0] wb_dat_i,
    output logic [mmio_pkg::DATA_W-1:0] wb_dat_o,
    output logic                        wb_ack_o
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [mmio_pkg::DATA_W-1:0] mem [RAM_WORDS];
    logic [IDX_W-1:0]            idx;
    logic                        served_q;
    logic                        hit;

    assign idx = wb_adr_i[IDX_W+1:2];              // byte address to word index
    assign hit = wb_cyc_i && wb_stb_i && !wb_ack_o && !served_q;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            wb_ack_o <= 1'b0;
            served_q <= 1'b0;
        end else begin
            wb_ack_o <= hit;                       // single cycle ack
            served_q <= wb_stb_i && (served_q || wb_ack_o);  // no second ack while stb held
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            if (wb_we_i) begin
                mem[idx] <= wb_dat_i;
            end
            wb_dat_o <= mem[idx];
        end
    end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!nRst)
        wb_ack_o |-> wb_cyc_i);

endmodule

// ==== verilog/spi_display_tx.sv ====
module spi_display_tx #(
    parameter int SPI_CLK_DIV = 4
) (
    input  logic       clk,
    input  logic       nRst,
    input  logic       start_i,
    input  logic       is_param_i,
    input  logic [7:0] byte_i,
    output logic       busy_o,
    output logic       sclk_o,
    output logic       mosi_o,
    output logic       dc_o,
    output logic       cs_n_o
);

    localparam int DIV_W = (SPI_CLK_DIV > 1) ? $clog2(SPI_CLK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SPI_CLK_DIV - 1);

    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_SHIFT = 2'd1,
        TX_HOLD  = 2'd2
    } tx_state_e;

    tx_state_e        state_q;
    logic [DIV_W-1:0] div_q;
    logic [2:0]       bit_q;
    logic [7:0]       shift_q;
    logic             half_tick;

    assign half_tick = (div_q == DIV_LAST);        // end of a serial clock half period

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state_q <= TX_IDLE;
            div_q   <= '0;
            bit_q   <= '0;
            shift_q <= '0;
            sclk_o  <= 1'b0;
            dc_o    <= 1'b0;
            cs_n_o  <= 1'b1;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    div_q  <= '0;
                    sclk_o <= 1'b0;
                    if (start_i) begin
                        shift_q <= byte_i;
                        dc_o    <= is_param_i;     // held for the whole byte
                        bit_q   <= '0;
                        cs_n_o  <= 1'b0;
                        state_q <= TX_SHIFT;
                    end
                end
                TX_SHIFT: begin
                    div_q <= half_tick ? '0 : div_q + 1'b1;
                    if (half_tick) begin
                        if (!sclk_o) begin
                            sclk_o <= 1'b1;        // display samples here
                        end else begin
                            sclk_o <= 1'b0;
                            if (bit_q == 3'd7) begin
                                state_q <= TX_HOLD;
                            end else begin
                                shift_q <= {shift_q[6:0], 1'b0};
                                bit_q   <= bit_q + 3'd1;
                            end
                        end
                    end
                end
                TX_HOLD: begin
                    div_q <= half_tick ? '0 : div_q + 1'b1;
                    if (half_tick) begin
                        cs_n_o  <= 1'b1;           // cs hold done
                        state_q <= TX_IDLE;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    assign mosi_o = shift_q[7];                    // msb first
    assign busy_o = (state_q != TX_IDLE);

    a_cs_idle: assert property (@(posedge clk) disable iff (!nRst)
        !busy_o |-> cs_n_o);

endmodule

// ==== verilog/mmio_subsys.sv ====
module mmio_subsys #(
    parameter int RAM_WORDS   = 512,
    parameter int SPI_CLK_DIV = 4
) (
    input  logic                        clk,
    input  logic                        nRst,
    input  logic                        read_i,
    input  logic                        write_i,
    input  logic [mmio_pkg::DATA_W-1:0] address_i,
    input  logic [mmio_pkg::DATA_W-1:0] data_i,
    input  logic [mmio_pkg::DATA_W-1:0] touch_xy_i,
    input  logic                        touch_done_i,
    output logic [mmio_pkg::DATA_W-1:0] data_o,
    output logic                        busy_o,
    output logic                        done_o,
    output logic                        touch_ready_o,
    output logic                        spi_sclk_o,
    output logic                        spi_mosi_o,
    output logic                        spi_dc_o,
    output logic                        spi_cs_n_o
);

    // decoder to memory master
    logic                        mem_start, mem_we, mem_done;
    logic [mmio_pkg::DATA_W-1:0] mem_adr, mem_wdata, mem_rdata;

    // wishbone
    logic                        wb_cyc, wb_stb, wb_we, wb_ack;
    logic [mmio_pkg::DATA_W-1:0] wb_adr, wb_dat_w, wb_dat_r;

    // decoder to display
    logic       spi_start, spi_is_param, spi_busy;
    logic [7:0] spi_byte;

    assign touch_ready_o = touch_done_i;

    mmio_decoder u_decoder (
        .clk            (clk),
        .nRst           (nRst),
        .read_i         (read_i),
        .write_i        (write_i),
        .address_i      (address_i),
        .data_i         (data_i),
        .mem_done_i     (mem_done),
        .mem_rdata_i    (mem_rdata),
        .spi_busy_i     (spi_busy),
        .touch_xy_i     (touch_xy_i),
        .touch_done_i   (touch_done_i),
        .data_o         (data_o),
        .busy_o         (busy_o),
        .done_o         (done_o),
        .mem_start_o    (mem_start),
        .mem_we_o       (mem_we),
        .mem_adr_o      (mem_adr),
        .mem_wdata_o    (mem_wdata),
        .spi_start_o    (spi_start),
        .spi_is_param_o (spi_is_param),
        .spi_byte_o     (spi_byte)
    );

    wb_mem_master u_mem_master (
        .clk      (clk),
        .nRst     (nRst),
        .start_i  (mem_start),
        .we_i     (mem_we),
        .adr_i    (mem_adr),
        .wdata_i  (mem_wdata),
        .rdata_o  (mem_rdata),
        .done_o   (mem_done),
        .wb_cyc_o (wb_cyc),
        .wb_stb_o (wb_stb),
        .wb_we_o  (wb_we),
        .wb_adr_o (wb_adr),
        .wb_dat_o (wb_dat_w),
        .wb_dat_i (wb_dat_r),
        .wb_ack_i (wb_ack)
    );

    wb_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .clk      (clk),
        .nRst     (nRst),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    spi_display_tx #(
        .SPI_CLK_DIV (SPI_CLK_DIV)
    ) u_spi_tx (
        .clk        (clk),
        .nRst       (nRst),
        .start_i    (spi_start),
        .is_param_i (spi_is_param),
        .byte_i     (spi_byte),
        .busy_o     (spi_busy),
        .sclk_o     (spi_sclk_o),
        .mosi_o     (spi_mosi_o),
        .dc_o       (spi_dc_o),
        .cs_n_o     (spi_cs_n_o)
    );

endmodule

// ==== verif/spi_capture.sv ====
module spi_capture (
    input  logic       nRst,
    input  logic       sclk_i,
    input  logic       mosi_i,
    input  logic       dc_i,
    input  logic       cs_n_i,
    output logic [7:0] byte_o,
    output logic       dc_o,
    output int         count_o
);

    logic [7:0] shift_q;
    logic [2:0] bit_q;

    // mode 0, so mosi is sampled on the rising serial clock
    always @(posedge sclk_i or posedge cs_n_i or negedge nRst) begin
        if (!nRst) begin
            shift_q <= '0;
            bit_q   <= '0;
            byte_o  <= '0;
            dc_o    <= 1'b0;
            count_o <= 0;
        end else if (cs_n_i) begin
            bit_q <= '0;                           // deselect restarts the byte
        end else begin
            shift_q <= {shift_q[6:0], mosi_i};     // msb arrives first
            bit_q   <= bit_q + 3'd1;
            if (bit_q == 3'd7) begin
                byte_o  <= {shift_q[6:0], mosi_i};
                dc_o    <= dc_i;
                count_o <= count_o + 1;
            end
        end
    end

endmodule

// ==== verif/tb_mmio_subsys.sv ====
module tb_mmio_subsys;

    localparam int RAM_WORDS   = 512;
    localparam int SPI_CLK_DIV = 4;
    localparam int TIMEOUT     = 40 * SPI_CLK_DIV + 40;  // cycles, one display byte fits well

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_BOTH
    } op_e;

    typedef struct {
        string                       name;
        op_e                         op;
        logic [mmio_pkg::DATA_W-1:0] addr;
        logic [mmio_pkg::DATA_W-1:0] wdata;
        logic [mmio_pkg::DATA_W-1:0] xy;
        logic                        tdone;
        mmio_pkg::mmio_target_e      route;
        logic                        chk_data;
        logic [mmio_pkg::DATA_W-1:0] rdata;
        logic [7:0]                  sbyte;
        logic                        sdc;
    } entry_t;

    logic                        clk;
    logic                        nRst;
    logic                        read_i;
    logic                        write_i;
    logic [mmio_pkg::DATA_W-1:0] address_i;
    logic [mmio_pkg::DATA_W-1:0] data_i;
    logic [mmio_pkg::DATA_W-1:0] touch_xy_i;
    logic                        touch_done_i;
    logic [mmio_pkg::DATA_W-1:0] data_o;
    logic                        busy_o;
    logic                        done_o;
    logic                        touch_ready_o;
    logic                        spi_sclk_o;
    logic                        spi_mosi_o;
    logic                        spi_dc_o;
    logic                        spi_cs_n_o;
    logic [7:0]                  cap_byte;
    logic                        cap_dc;
    int                          cap_count;

    entry_t                      table_q[$];
    logic [mmio_pkg::DATA_W-1:0] ref_mem [logic [29:0]];   // word address to last written value

    mmio_subsys #(
        .RAM_WORDS   (RAM_WORDS),
        .SPI_CLK_DIV (SPI_CLK_DIV)
    ) uut (
        .clk           (clk),
        .nRst          (nRst),
        .read_i        (read_i),
        .write_i       (write_i),
        .address_i     (address_i),
        .data_i        (data_i),
        .touch_xy_i    (touch_xy_i),
        .touch_done_i  (touch_done_i),
        .data_o        (data_o),
        .busy_o        (busy_o),
        .done_o        (done_o),
        .touch_ready_o (touch_ready_o),
        .spi_sclk_o    (spi_sclk_o),
        .spi_mosi_o    (spi_mosi_o),
        .spi_dc_o      (spi_dc_o),
        .spi_cs_n_o    (spi_cs_n_o)
    );

    spi_capture u_capture (
        .nRst    (nRst),
        .sclk_i  (spi_sclk_o),
        .mosi_i  (spi_mosi_o),
        .dc_i    (spi_dc_o),
        .cs_n_i  (spi_cs_n_o),
        .byte_o  (cap_byte),
        .dc_o    (cap_dc),
        .count_o (cap_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic word_check(input string name, input logic [mmio_pkg::DATA_W-1:0] exp,
                              input logic [mmio_pkg::DATA_W-1:0] act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic serial_check(input string name, input logic [7:0] exp_b, input logic exp_dc,
                                input logic [7:0] act_b, input logic act_dc);
        if (act_b !== exp_b || act_dc !== exp_dc) begin
            report_failure($sformatf("mismatch %s: expected byte %h dc %b actual byte %h dc %b",
                                     name, exp_b, exp_dc, act_b, act_dc));
        end
    endtask

    task automatic route_check(input string name, input mmio_pkg::mmio_target_e exp,
                               input mmio_pkg::mmio_target_e act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s: expected %s actual %s",
                                     name, exp.name(), act.name()));
        end
    endtask

    task automatic flag_check(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s: expected %b actual %b", name, exp, act));
        end
    endtask

    // address map as the memory handler sees it
    function automatic mmio_pkg::mmio_target_e expected_route(
            input logic [mmio_pkg::DATA_W-1:0] addr);
        if (addr < 32'd2048) return mmio_pkg::TGT_MEM;
        if (addr == 32'd121212) return mmio_pkg::TGT_SPI_CMD;
        if (addr == 32'd333333) return mmio_pkg::TGT_SPI_PARAM;
        if (addr == 32'd923923) return mmio_pkg::TGT_TOUCH;
        return mmio_pkg::TGT_NONE;
    endfunction

    // touch, unmapped and display reads leave no trace on the bus or the pins
    function automatic mmio_pkg::mmio_target_e visible_route(input entry_t e);
        if (e.op == OP_BOTH || e.route == mmio_pkg::TGT_TOUCH) return mmio_pkg::TGT_NONE;
        if (e.op == OP_READ && e.route != mmio_pkg::TGT_MEM) return mmio_pkg::TGT_NONE;
        return e.route;
    endfunction

    task automatic add_entry(input string name, input op_e op,
                             input logic [mmio_pkg::DATA_W-1:0] addr,
                             input logic [mmio_pkg::DATA_W-1:0] wdata,
                             input logic [mmio_pkg::DATA_W-1:0] xy, input logic tdone);
        entry_t e;
        e.name     = name;
        e.op       = op;
        e.addr     = addr;
        e.wdata    = wdata;
        e.xy       = xy;
        e.tdone    = tdone;
        e.route    = (op == OP_BOTH) ? mmio_pkg::TGT_NONE : expected_route(addr);
        e.chk_data = (op != OP_BOTH);
        e.rdata    = '0;                           // writes and unmapped reads return zero
        e.sbyte    = '0;
        e.sdc      = 1'b0;
        if (op == OP_WRITE && e.route == mmio_pkg::TGT_MEM) begin
            ref_mem[addr[31:2]] = wdata;
        end else if (op == OP_WRITE && e.route inside {mmio_pkg::TGT_SPI_CMD,
                                                      mmio_pkg::TGT_SPI_PARAM}) begin
            e.sbyte = wdata[7:0];
            e.sdc   = (e.route == mmio_pkg::TGT_SPI_PARAM);
        end else if (op == OP_READ && e.route == mmio_pkg::TGT_MEM) begin
            e.chk_data = ref_mem.exists(addr[31:2]);   // unwritten words are unknown
            if (e.chk_data) begin
                e.rdata = ref_mem[addr[31:2]];
            end
        end else if (op == OP_READ && e.route == mmio_pkg::TGT_TOUCH) begin
            e.rdata = tdone ? xy : '0;
        end
        table_q.push_back(e);
    endtask

    task automatic build_table();
        logic [mmio_pkg::DATA_W-1:0] ram_addr [5];
        ram_addr = '{32'h0, 32'h4, 32'h100, 32'h400, 32'h7fc};
        foreach (ram_addr[i]) begin
            add_entry($sformatf("ram_wr_%0d", i), OP_WRITE, ram_addr[i], $urandom(), '0, 1'b0);
        end
        add_entry("ram_overwrite", OP_WRITE, 32'h100, $urandom(), '0, 1'b0);
        foreach (ram_addr[i]) begin
            add_entry($sformatf("ram_rd_%0d", i), OP_READ, ram_addr[i], '0, '0, 1'b0);
        end
        add_entry("disp_cmd", OP_WRITE, mmio_pkg::SPI_CMD_ADDR, $urandom(), '0, 1'b0);
        add_entry("disp_param", OP_WRITE, mmio_pkg::SPI_PARAM_ADDR, $urandom(), '0, 1'b0);
        add_entry("disp_back_to_back", OP_WRITE, mmio_pkg::SPI_CMD_ADDR, $urandom(), '0, 1'b1);
        add_entry("disp_read", OP_READ, mmio_pkg::SPI_CMD_ADDR, '0, '0, 1'b0);
        add_entry("touch_ready", OP_READ, mmio_pkg::TOUCH_ADDR, '0, $urandom(), 1'b1);
        add_entry("touch_not_ready", OP_READ, mmio_pkg::TOUCH_ADDR, '0, $urandom(), 1'b0);
        add_entry("unmapped_rd", OP_READ, 32'd5000, '0, '0, 1'b0);
        add_entry("unmapped_wr", OP_WRITE, 32'h900, $urandom(), '0, 1'b0);  // aliases 0x100
        add_entry("touch_wr", OP_WRITE, mmio_pkg::TOUCH_ADDR, $urandom(), $urandom(), 1'b1);
        add_entry("both_high", OP_BOTH, 32'h4, $urandom(), '0, 1'b0);
        foreach (ram_addr[i]) begin
            add_entry($sformatf("ram_recheck_%0d", i), OP_READ, ram_addr[i], '0, '0, 1'b0);
        end
    endtask

    task automatic run_entry(input entry_t e);
        int                     start_count;
        int                     cyc;
        logic                   got_done;
        logic                   saw_mem;
        logic                   saw_busy;
        mmio_pkg::mmio_target_e seen;
        start_count  = cap_count;
        got_done     = 1'b0;
        saw_mem      = 1'b0;
        saw_busy     = 1'b0;
        cyc          = 0;
        read_i       = (e.op != OP_WRITE);
        write_i      = (e.op != OP_READ);
        address_i    = e.addr;
        data_i       = e.wdata;
        touch_xy_i   = e.xy;
        touch_done_i = e.tdone;
        while (!got_done && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
            saw_mem  = saw_mem | uut.wb_cyc;
            saw_busy = saw_busy | busy_o;
            flag_check({e.name, " touch_ready"}, touch_done_i, touch_ready_o);
            if (!spi_cs_n_o && !busy_o) begin
                report_failure($sformatf("%s: busy_o low while a display byte shifts", e.name));
            end
            if (done_o) begin
                got_done = 1'b1;
            end else begin
                word_check({e.name, " data before done"}, '0, data_o);
            end
        end
        if (e.op == OP_BOTH && got_done) begin
            report_failure($sformatf("%s: done_o pulsed with read and write both high", e.name));
        end
        if (e.op != OP_BOTH && !got_done) begin
            report_failure($sformatf("%s: timeout waiting for done_o", e.name));
        end
        if (e.chk_data) begin
            word_check(e.name, e.rdata, data_o);
        end
        read_i  = 1'b0;
        write_i = 1'b0;
        if (visible_route(e) inside {mmio_pkg::TGT_SPI_CMD, mmio_pkg::TGT_SPI_PARAM}) begin
            cyc = 0;
            while (cap_count == start_count && cyc < TIMEOUT) begin
                @(negedge clk);
                cyc++;
            end
            if (cap_count == start_count) begin
                report_failure($sformatf("%s: timeout waiting for a display byte", e.name));
            end
            serial_check(e.name, e.sbyte, e.sdc, cap_byte, cap_dc);
            flag_check({e.name, " busy while shifting"}, 1'b1, saw_busy);
        end
        if (cap_count > start_count + 1) begin
            report_failure($sformatf("%s: more than one display byte sent", e.name));
        end
        if (saw_mem) begin
            seen = mmio_pkg::TGT_MEM;
        end else if (cap_count != start_count) begin
            seen = cap_dc ? mmio_pkg::TGT_SPI_PARAM : mmio_pkg::TGT_SPI_CMD;
        end else begin
            seen = mmio_pkg::TGT_NONE;
        end
        route_check({e.name, " route"}, visible_route(e), seen);
        @(negedge clk);                            // requester idle for a cycle
    endtask

    initial begin
        nRst         = 1'b0;
        read_i       = 1'b0;
        write_i      = 1'b0;
        address_i    = '0;
        data_i       = '0;
        touch_xy_i   = '0;
        touch_done_i = 1'b0;
        void'($urandom(32'h8d4ec7e2));             // seeds the generator once
        build_table();
        repeat (16) @(negedge clk);
        nRst = 1'b1;
        @(negedge clk);
        flag_check("reset busy_o", 1'b0, busy_o);
        flag_check("reset done_o", 1'b0, done_o);
        flag_check("reset spi_cs_n_o", 1'b1, spi_cs_n_o);
        foreach (table_q[i]) begin
            run_entry(table_q[i]);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/mmio_pkg.sv
verilog/mmio_decoder.sv
verilog/wb_mem_master.sv
verilog/wb_ram.sv
verilog/spi_display_tx.sv
verilog/mmio_subsys.sv
verif/spi_capture.sv
verif/tb_mmio_subsys.sv

// ==== Bender.yml ====
package:
  name: mmio_subsys

sources:
  - files:
      - verilog/mmio_pkg.sv
      - verilog/mmio_decoder.sv
      - verilog/wb_mem_master.sv
      - verilog/wb_ram.sv
      - verilog/spi_display_tx.sv
      - verilog/mmio_subsys.sv
  - target: test
    files:
      - verif/spi_capture.sv
      - verif/tb_mmio_subsys.sv
